// ==== eeprom_pkg.sv ====
package eeprom_pkg;

    // one bus byte or one memory word
    typedef logic [7:0] byte_t;

    // {block bits, word byte}
    typedef logic [10:0] mem_addr_t;

    // block bits of the control byte
    typedef logic [2:0] block_t;

    // bit slot inside a frame, 0 to 8
    typedef logic [3:0] slot_cnt_t;

    // controller states
    typedef enum logic [2:0]
    {
        CS_IDLE,
        CS_DEV_ADDR,
        CS_WORD_ADDR,
        CS_WRITE_DATA,
        CS_READ_DATA,
        CS_IGNORE
    } ctrl_state_t;

    // high nibble of a valid control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // storage depth, 8 blocks of 256 words
    localparam int MEM_WORDS = 2048;

    // eight data slots come first, then the acknowledge slot
    localparam slot_cnt_t SLOT_ACK = 4'd8;

endpackage

// ==== bus_sampler.sv ====
module bus_sampler
(
    input  logic scl,
    input  logic arst_n,
    input  logic bus_clk,
    input  logic bus_data,
    output logic clk_rise,
    output logic clk_fall,
    output logic start_seen,
    output logic stop_seen,
    output logic data_bit
);

    logic clk_s1;
    logic clk_s2;
    logic data_s1;
    logic data_s2;
    // previous synchronized levels
    logic clk_d;
    logic data_d;

    // two stage synchronizers, idle bus is high
    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clk_s1  <= 1'b1;
            clk_s2  <= 1'b1;
            data_s1 <= 1'b1;
            data_s2 <= 1'b1;
            clk_d   <= 1'b1;
            data_d  <= 1'b1;
        end
        else
        begin
            clk_s1  <= bus_clk;
            clk_s2  <= clk_s1;
            data_s1 <= bus_data;
            data_s2 <= data_s1;
            clk_d   <= clk_s2;
            data_d  <= data_s2;
        end
    end

    // the clock must be high in both samples, so a data edge that
    // lands together with a clock edge is no start or stop
    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clk_rise   <= 1'b0;
            clk_fall   <= 1'b0;
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
        end
        else
        begin
            clk_rise   <= clk_s2 & ~clk_d;
            clk_fall   <= ~clk_s2 & clk_d;
            start_seen <= clk_s2 & clk_d & data_d & ~data_s2;
            stop_seen  <= clk_s2 & clk_d & ~data_d & data_s2;
        end
    end

    // aligned with the pulses above
    assign data_bit = data_d;

endmodule

// ==== byte_shifter.sv ====
module byte_shifter
(
    input  logic              scl,
    input  logic              arst_n,
    input  logic              clk_rise,
    input  logic              clk_fall,
    input  logic              start_seen,
    input  logic              stop_seen,
    input  logic              data_bit,
    input  logic              load,
    input  eeprom_pkg::byte_t load_byte,
    output eeprom_pkg::byte_t rx_byte,
    output logic              byte_done,
    output logic              ack_bit,
    output logic              frame_end,
    output logic              tx_bit
);

    import eeprom_pkg::*;

    slot_cnt_t slot;
    logic      ack_seen;
    byte_t     rx_shift;
    byte_t     tx_shift;

    // slot counts rises; it stops at the ack slot and the 9th rise
    // only marks ack_seen
    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            slot      <= '0;
            ack_seen  <= 1'b0;
            ack_bit   <= 1'b1;
            byte_done <= 1'b0;
            frame_end <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            frame_end <= 1'b0;
            if (start_seen || stop_seen)
            begin
                slot     <= '0;
                ack_seen <= 1'b0;
            end
            else if (clk_rise)
            begin
                if (slot == SLOT_ACK)
                begin
                    ack_bit  <= data_bit;
                    ack_seen <= 1'b1;
                end
                else
                    slot <= slot + 1'b1;
            end
            else if (clk_fall && slot == SLOT_ACK)
            begin
                if (ack_seen)
                begin
                    frame_end <= 1'b1;
                    slot      <= '0;
                    ack_seen  <= 1'b0;
                end
                else
                    // byte complete, ack slot opens on this fall
                    byte_done <= 1'b1;
            end
        end
    end

    // receive path, msb first
    always_ff @(posedge scl)
    begin
        if (clk_rise && slot != SLOT_ACK)
            rx_shift <= {rx_shift[6:0], data_bit};
        if (clk_fall && slot == SLOT_ACK && !ack_seen)
            rx_byte <= rx_shift;
    end

    // transmit path, ones fill behind the last bit
    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
            tx_shift <= '1;
        else if (frame_end && load)
            tx_shift <= load_byte;
        else if (clk_fall && slot != '0 && slot < SLOT_ACK)
            tx_shift <= {tx_shift[6:0], 1'b1};
    end

    assign tx_bit = tx_shift[7];

endmodule

// ==== eeprom_array.sv ====
module eeprom_array
(
    input  logic                  scl,
    input  logic                  arst_n,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  eeprom_pkg::mem_addr_t addr,
    input  eeprom_pkg::byte_t     wr_data,
    output eeprom_pkg::byte_t     rd_data,
    output logic                  array_busy
);

    import eeprom_pkg::*;

    byte_t     mem [MEM_WORDS];
    mem_addr_t sweep_ptr;

    // clear sweep, one word per cycle after reset release
    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            array_busy <= 1'b1;
            sweep_ptr  <= '0;
        end
        else if (array_busy)
        begin
            sweep_ptr <= sweep_ptr + 1'b1;
            if (sweep_ptr == mem_addr_t'(MEM_WORDS - 1))
                array_busy <= 1'b0;
        end
    end

    // single write port, the sweep has priority
    always_ff @(posedge scl)
    begin
        if (array_busy)
            mem[sweep_ptr] <= '0;
        else if (wr_en)
            mem[addr] <= wr_data;
    end

    // read data holds until the next rd_en
    always_ff @(posedge scl)
    begin
        if (rd_en)
            rd_data <= mem[addr];
    end

endmodule

// ==== eeprom_ctrl.sv ====
module eeprom_ctrl
(
    input  logic                  scl,
    input  logic                  arst_n,
    input  logic                  start_seen,
    input  logic                  stop_seen,
    input  logic                  byte_done,
    input  logic                  frame_end,
    input  eeprom_pkg::byte_t     rx_byte,
    input  logic                  ack_bit,
    input  logic                  tx_bit,
    input  logic                  array_busy,
    input  eeprom_pkg::byte_t     rd_data,
    output logic                  load,
    output eeprom_pkg::byte_t     load_byte,
    output logic                  wr_en,
    output logic                  rd_en,
    output eeprom_pkg::mem_addr_t addr,
    output eeprom_pkg::byte_t     wr_data,
    output logic                  bus_data_pull
);

    import eeprom_pkg::*;

    ctrl_state_t state;
    block_t      block;
    mem_addr_t   ptr;
    // high from byte_done to frame_end
    logic        ack_slot;
    logic        ack_ok;
    // one data byte per write transfer
    logic        wr_done;

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= CS_IDLE;
            block    <= '0;
            ptr      <= '0;
            ack_slot <= 1'b0;
            ack_ok   <= 1'b0;
            wr_done  <= 1'b0;
            wr_en    <= 1'b0;
            rd_en    <= 1'b0;
        end
        else
        begin
            wr_en <= 1'b0;
            rd_en <= 1'b0;
            if (array_busy)
            begin
                state    <= CS_IDLE;
                ack_slot <= 1'b0;
                ack_ok   <= 1'b0;
            end
            else if (stop_seen || start_seen)
            begin
                state    <= stop_seen ? CS_IDLE : CS_DEV_ADDR;
                ack_slot <= 1'b0;
                ack_ok   <= 1'b0;
                wr_done  <= 1'b0;
            end
            else if (byte_done)
            begin
                ack_slot <= 1'b1;
                ack_ok   <= 1'b0;
                case (state)
                    CS_DEV_ADDR:
                    begin
                        if (rx_byte[7:4] != DEVICE_CODE)
                            state <= CS_IGNORE;
                        else if (rx_byte[0])
                        begin
                            // block bits of the read control byte, word from before
                            ack_ok <= 1'b1;
                            ptr    <= {rx_byte[3:1], ptr[7:0]};
                            rd_en  <= 1'b1;
                            state  <= CS_READ_DATA;
                        end
                        else
                        begin
                            ack_ok <= 1'b1;
                            block  <= rx_byte[3:1];
                            state  <= CS_WORD_ADDR;
                        end
                    end
                    CS_WORD_ADDR:
                    begin
                        ack_ok <= 1'b1;
                        ptr    <= {block, rx_byte};
                        state  <= CS_WRITE_DATA;
                    end
                    CS_WRITE_DATA:
                    begin
                        if (!wr_done)
                        begin
                            ack_ok  <= 1'b1;
                            wr_en   <= 1'b1;
                            wr_done <= 1'b1;
                        end
                    end
                    CS_READ_DATA:
                    begin
                        // fetch the next word now, it is loaded only on a master ack
                        ptr   <= ptr + 1'b1;
                        rd_en <= 1'b1;
                    end
                    default:
                    begin
                    end
                endcase
            end
            else if (frame_end)
            begin
                ack_slot <= 1'b0;
                ack_ok   <= 1'b0;
                if (state == CS_READ_DATA && ack_bit)
                    state <= CS_IDLE;
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (byte_done)
            wr_data <= rx_byte;
    end

    assign addr      = ptr;
    assign load_byte = rd_data;
    // after the control byte our own ack reads back low, so this covers both frames
    assign load      = (state == CS_READ_DATA) && !ack_bit;

    always_comb
    begin
        if (ack_slot)
            bus_data_pull = ack_ok;
        else if (state == CS_READ_DATA)
            bus_data_pull = ~tx_bit;
        else
            bus_data_pull = 1'b0;
    end

endmodule

// ==== i2c_eeprom.sv ====
module i2c_eeprom
(
    input  logic scl,
    input  logic arst_n,
    input  logic bus_clk,
    input  logic bus_data,
    output logic bus_data_pull
);

    import eeprom_pkg::*;

    logic      clk_rise;
    logic      clk_fall;
    logic      start_seen;
    logic      stop_seen;
    logic      data_bit;
    logic      load;
    byte_t     load_byte;
    byte_t     rx_byte;
    logic      byte_done;
    logic      ack_bit;
    logic      frame_end;
    logic      tx_bit;
    logic      wr_en;
    logic      rd_en;
    mem_addr_t addr;
    byte_t     wr_data;
    byte_t     rd_data;
    logic      array_busy;

    bus_sampler u_bus_sampler
    (
        .scl        (scl),
        .arst_n     (arst_n),
        .bus_clk    (bus_clk),
        .bus_data   (bus_data),
        .clk_rise   (clk_rise),
        .clk_fall   (clk_fall),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .data_bit   (data_bit)
    );

    byte_shifter u_byte_shifter
    (
        .scl        (scl),
        .arst_n     (arst_n),
        .clk_rise   (clk_rise),
        .clk_fall   (clk_fall),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .data_bit   (data_bit),
        .load       (load),
        .load_byte  (load_byte),
        .rx_byte    (rx_byte),
        .byte_done  (byte_done),
        .ack_bit    (ack_bit),
        .frame_end  (frame_end),
        .tx_bit     (tx_bit)
    );

    eeprom_ctrl u_eeprom_ctrl
    (
        .scl           (scl),
        .arst_n        (arst_n),
        .start_seen    (start_seen),
        .stop_seen     (stop_seen),
        .byte_done     (byte_done),
        .frame_end     (frame_end),
        .rx_byte       (rx_byte),
        .ack_bit       (ack_bit),
        .tx_bit        (tx_bit),
        .array_busy    (array_busy),
        .rd_data       (rd_data),
        .load          (load),
        .load_byte     (load_byte),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .addr          (addr),
        .wr_data       (wr_data),
        .bus_data_pull (bus_data_pull)
    );

    eeprom_array u_eeprom_array
    (
        .scl        (scl),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .addr       (addr),
        .wr_data    (wr_data),
        .rd_data    (rd_data),
        .array_busy (array_busy)
    );

endmodule

// ==== tb_clock.sv ====
module tb_clock
(
    output logic scl,
    output logic arst_n
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial
    begin
        scl    = 1'b0;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge scl);
        arst_n <= 1'b1;
    end

    // period of 10
    always #HALF_PERIOD scl = ~scl;

endmodule

// ==== i2c_eeprom_sva.sv ====
module i2c_eeprom_sva
(
    input logic                    scl,
    input logic                    arst_n,
    input eeprom_pkg::ctrl_state_t state,
    input logic                    bus_data_pull,
    input logic                    wr_en,
    input logic                    rd_en,
    input logic                    array_busy
);

    import eeprom_pkg::*;

    // device stays off the line unless addressed
    pull_off_when_idle: assert property (@(posedge scl) disable iff (!arst_n)
        (state == CS_IDLE || state == CS_IGNORE) |-> !bus_data_pull)
        else $error("bus_data_pull high while the controller is idle or ignoring");

    wr_en_one_cycle: assert property (@(posedge scl) disable iff (!arst_n)
        wr_en |=> !wr_en)
        else $error("wr_en held for more than one cycle");

    rd_en_one_cycle: assert property (@(posedge scl) disable iff (!arst_n)
        rd_en |=> !rd_en)
        else $error("rd_en held for more than one cycle");

    // the clear sweep owns the write port
    no_write_while_busy: assert property (@(posedge scl) disable iff (!arst_n)
        $rose(wr_en) |-> !array_busy)
        else $error("wr_en rose during the clear sweep");

endmodule

bind eeprom_ctrl i2c_eeprom_sva u_i2c_eeprom_sva
(
    .scl           (scl),
    .arst_n        (arst_n),
    .state         (state),
    .bus_data_pull (bus_data_pull),
    .wr_en         (wr_en),
    .rd_en         (rd_en),
    .array_busy    (array_busy)
);

// ==== tb_i2c_eeprom.sv ====
module tb_i2c_eeprom;

    import eeprom_pkg::*;

    localparam int         HALF_CYCLES   = 8;
    localparam int         SETTLE_CYCLES = 2100;
    localparam int         RESET_TIMEOUT = 100;
    localparam int         BUS_TIMEOUT   = 200;
    localparam int         MAX_BYTES     = 8;
    localparam int         SEED          = 43347;
    localparam logic [3:0] GOOD_CODE     = 4'b1010;
    localparam logic [3:0] BAD_CODE      = 4'b1110;

    logic  scl;
    logic  arst_n;
    logic  bus_clk = 1'b1;
    logic  sda_drv = 1'b1;
    logic  bus_data;
    logic  bus_data_pull;
    // data or expected bytes of the current stimulus line
    byte_t line_data [MAX_BYTES];
    int    ops_run;

    // wired line from the master level and the device pull
    assign bus_data = sda_drv & ~bus_data_pull;

    tb_clock u_tb_clock
    (
        .scl    (scl),
        .arst_n (arst_n)
    );

    i2c_eeprom u_i2c_eeprom
    (
        .scl           (scl),
        .arst_n        (arst_n),
        .bus_clk       (bus_clk),
        .bus_data      (bus_data),
        .bus_data_pull (bus_data_pull)
    );

    task automatic fail_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_ack(input string name, input logic exp, input logic got);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t got);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s is %02h, expected %02h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (arst_n !== 1'b1 && n < RESET_TIMEOUT)
        begin
            @(posedge scl);
            n++;
        end
        if (arst_n !== 1'b1)
        begin
            $display("timeout: reset was never released");
            fail_run();
        end
    endtask

    // line must be released by the device before a start
    task automatic wait_bus_free();
        int n;
        n = 0;
        @(negedge scl);
        while (bus_data !== 1'b1 && n < BUS_TIMEOUT)
        begin
            @(negedge scl);
            n++;
        end
        if (bus_data !== 1'b1)
        begin
            $display("timeout: the device kept the data line low");
            fail_run();
        end
    endtask

    task automatic wait_half();
        repeat (HALF_CYCLES) @(posedge scl);
    endtask

    task automatic bus_start();
        wait_bus_free();
        @(posedge scl);
        sda_drv <= 1'b1;
        wait_half();
        bus_clk <= 1'b1;
        wait_half();
        sda_drv <= 1'b0;
        wait_half();
        bus_clk <= 1'b0;
    endtask

    task automatic bus_stop();
        @(posedge scl);
        sda_drv <= 1'b0;
        wait_half();
        bus_clk <= 1'b1;
        wait_half();
        sda_drv <= 1'b1;
        wait_half();
    endtask

    task automatic send_bit(input logic b);
        @(posedge scl);
        sda_drv <= b;
        wait_half();
        bus_clk <= 1'b1;
        wait_half();
        bus_clk <= 1'b0;
    endtask

    task automatic recv_bit(output logic b);
        @(posedge scl);
        sda_drv <= 1'b1;
        wait_half();
        bus_clk <= 1'b1;
        repeat (HALF_CYCLES - 1) @(posedge scl);
        // sample just before the clock falls
        @(negedge scl);
        b = bus_data;
        @(posedge scl);
        bus_clk <= 1'b0;
    endtask

    task automatic send_byte(input byte_t data, output logic ack);
        for (int i = 7; i >= 0; i--)
            send_bit(data[i]);
        recv_bit(ack);
    endtask

    // low in the ack slot asks for one more byte
    task automatic read_byte(input logic more, output byte_t data);
        logic b;
        for (int i = 7; i >= 0; i--)
        begin
            recv_bit(b);
            data[i] = b;
        end
        send_bit(!more);
    endtask

    task automatic address_phase(input mem_addr_t a);
        logic ack;
        bus_start();
        send_byte({GOOD_CODE, a[10:8], 1'b0}, ack);
        check_ack("bus_data in ack slot of write control byte", 1'b0, ack);
        send_byte(a[7:0], ack);
        check_ack("bus_data in ack slot of word address", 1'b0, ack);
    endtask

    task automatic write_byte(input mem_addr_t a, input byte_t data);
        logic ack;
        address_phase(a);
        send_byte(data, ack);
        check_ack("bus_data in ack slot of data byte", 1'b0, ack);
        bus_stop();
    endtask

    task automatic read_seq(input mem_addr_t a, input int cnt);
        logic  ack;
        byte_t got;
        address_phase(a);
        bus_start();
        send_byte({GOOD_CODE, a[10:8], 1'b1}, ack);
        check_ack("bus_data in ack slot of read control byte", 1'b0, ack);
        for (int i = 0; i < cnt; i++)
        begin
            read_byte(i < cnt - 1, got);
            check_byte($sformatf("bus_data byte %0d read from %03h", i, a), line_data[i], got);
        end
        bus_stop();
    endtask

    // nothing on this transfer may be acknowledged
    task automatic bad_code_write(input mem_addr_t a, input byte_t data);
        logic ack;
        bus_start();
        send_byte({BAD_CODE, a[10:8], 1'b0}, ack);
        check_ack("bus_data in ack slot of bad control byte", 1'b1, ack);
        send_byte(a[7:0], ack);
        check_ack("bus_data in ack slot of ignored word", 1'b1, ack);
        send_byte(data, ack);
        check_ack("bus_data in ack slot of ignored data", 1'b1, ack);
        bus_stop();
    endtask

    task automatic abort_write(input mem_addr_t a, input byte_t data);
        address_phase(a);
        // half a data byte and then a stop
        for (int i = 7; i > 3; i--)
            send_bit(data[i]);
        bus_stop();
    endtask

    task automatic run_op(input logic [7:0] op, input mem_addr_t base, input int cnt);
        mem_addr_t a;
        case (op)
            "W":
            begin
                for (int i = 0; i < cnt; i++)
                begin
                    a = base + mem_addr_t'(i);
                    write_byte(a, line_data[i]);
                end
            end
            "R":
                read_seq(base, cnt);
            "S":
            begin
                // random words written across the top address and the wrap
                for (int i = 0; i < cnt; i++)
                begin
                    a = base + mem_addr_t'(i);
                    line_data[i] = byte_t'($urandom());
                    write_byte(a, line_data[i]);
                end
                read_seq(base, cnt);
            end
            "B":
                bad_code_write(base, line_data[0]);
            "A":
                abort_write(base, line_data[0]);
            default:
            begin
                $display("unknown operation %c in the stimulus file", op);
                fail_run();
            end
        endcase
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        // 10 is the newline
        while (c != 10 && c != -1)
            c = $fgetc(fd);
    endtask

    initial
    begin
        int         fd;
        int         n;
        int         cnt;
        logic [7:0] op;
        block_t     blk;
        byte_t      word;

        void'($urandom(SEED));
        ops_run = 0;
        wait_reset_release();
        // clear sweep runs first
        repeat (SETTLE_CYCLES) @(posedge scl);
        fd = $fopen("i2c_eeprom_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open i2c_eeprom_stimulus.txt");
            fail_run();
        end
        while ($fscanf(fd, " %c", op) == 1)
        begin
            if (op == "#")
                skip_line(fd);
            else
            begin
                n = $fscanf(fd, "%h %h %d", blk, word, cnt);
                if (n != 3 || cnt < 1 || cnt > MAX_BYTES)
                begin
                    $display("malformed line in the stimulus file after operation %c", op);
                    fail_run();
                end
                if (op != "S")
                begin
                    for (int i = 0; i < cnt; i++)
                    begin
                        if ($fscanf(fd, "%h", line_data[i]) != 1)
                        begin
                            $display("missing data byte in the stimulus file");
                            fail_run();
                        end
                    end
                end
                run_op(op, {blk, word}, cnt);
                ops_run++;
            end
        end
        $fclose(fd);
        if (ops_run > 0)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("no operations found in the stimulus file");
            fail_run();
        end
    end

endmodule

// ==== i2c_eeprom_stimulus.txt ====
# op block word count bytes, block and bytes in hex, count in decimal
# W write, R read and expect, S random fill then read, B bad device code, A aborted write
W 0 10 1 a5
R 0 10 1 a5
R 3 42 1 00
B 2 20 1 5c
R 2 20 1 00
W 2 20 1 c3
R 2 20 1 c3
W 0 77 1 11
W 5 77 1 99
R 0 77 1 11
R 5 77 1 99
R 0 77 2 11 00
S 7 fe 3
A 4 33 1 e7
R 4 33 1 00
W 4 33 1 3c
A 4 33 1 81
R 4 33 1 3c

// ==== i2c_eeprom.f ====
eeprom_pkg.sv
bus_sampler.sv
byte_shifter.sv
eeprom_array.sv
eeprom_ctrl.sv
i2c_eeprom.sv
tb_clock.sv
i2c_eeprom_sva.sv
tb_i2c_eeprom.sv

// ==== Makefile ====
TOP := tb_i2c_eeprom

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f i2c_eeprom.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
